// File: verilog/mac_defines.svh
// Widths and divider count; MAC_CLK_DIV must be 1 or more and data width is always twice half width
`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

// Half of the operand width
// The serial multiply takes twice this many steps
`define MAC_HALF_W 8

// Operand and accumulator width
// All arithmetic wraps modulo 2**MAC_DATA_W
`define MAC_DATA_W (2 * `MAC_HALF_W)

// Clock cycles per serial step minus one
// Any value of 1 or more is accepted
`define MAC_CLK_DIV 3

// Opcode field width of a host command
`define MAC_OP_W 2

// Result operation field width
`define MAC_RES_OP_W 2

`endif

// File: verilog/mac_pkg.sv
// Shared types for the MAC unit; struct widths follow mac_defines.svh and change only through it
`include "mac_defines.svh"

package mac_pkg;

    // Host opcodes
    typedef enum logic [`MAC_OP_W-1:0] {
        OP_CLEAR = 2'd0,
        OP_LOAD  = 2'd1,
        OP_MAC   = 2'd2,
        OP_RELU  = 2'd3
    } opcode_e;

    // Single-cycle accumulator actions
    typedef enum logic [`MAC_RES_OP_W-1:0] {
        RES_CLEAR = 2'd0,
        RES_LOAD  = 2'd1,
        RES_RELU  = 2'd2
    } res_op_e;

    // Command word from the host
    typedef struct packed {
        opcode_e                        op;
        logic signed [`MAC_DATA_W-1:0]  a;
        logic signed [`MAC_DATA_W-1:0]  b;
    } mac_cmd_t;

    // Operands for the serial executer
    typedef struct packed {
        logic signed [`MAC_DATA_W-1:0]  a;
        logic signed [`MAC_DATA_W-1:0]  b;
    } exec_req_t;

    // One-cycle update of the accumulator
    typedef struct packed {
        res_op_e                        op;
        logic signed [`MAC_DATA_W-1:0]  value;
    } res_req_t;

endpackage

// File: verilog/mac_decode.sv
// Command capture and dispatch; strobes arriving while busy are dropped, there is no queue
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_decode (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                cmd_valid_i,
    input  mac_pkg::mac_cmd_t   cmd_i,
    input  logic                done_i,
    output logic                busy_o,
    output logic                exec_start_o,
    output mac_pkg::exec_req_t  exec_req_o,
    output logic                res_strobe_o,
    output mac_pkg::res_req_t   res_req_o
);

    logic               busy_q;
    logic               capture;
    logic               is_mac;
    logic               exec_start_q;
    logic               res_strobe_q;
    mac_pkg::exec_req_t exec_req_q;
    mac_pkg::res_req_t  res_req_q;
    mac_pkg::res_req_t  res_req_d;

    // Only an idle unit accepts a command
    assign capture = cmd_valid_i && !busy_q;
    assign is_mac  = (cmd_i.op == mac_pkg::OP_MAC);

    // Map the single-cycle opcodes onto result actions
    always_comb begin
        res_req_d.op    = mac_pkg::RES_CLEAR;
        res_req_d.value = '0;
        case (cmd_i.op)
            mac_pkg::OP_LOAD: begin
                res_req_d.op    = mac_pkg::RES_LOAD;
                res_req_d.value = cmd_i.a;
            end
            mac_pkg::OP_RELU: begin
                res_req_d.op = mac_pkg::RES_RELU;
            end
            default: begin
                res_req_d.op = mac_pkg::RES_CLEAR;
            end
        endcase
    end

    // Busy from capture until the result stage reports completion
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            busy_q <= 1'b0;
        end else if (capture) begin
            busy_q <= 1'b1;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end
    end

    // Strobes leave one cycle after capture
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            exec_start_q <= 1'b0;
            res_strobe_q <= 1'b0;
        end else begin
            exec_start_q <= capture && is_mac;
            res_strobe_q <= capture && !is_mac;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            exec_req_q.a <= cmd_i.a;
            exec_req_q.b <= cmd_i.b;
            res_req_q    <= res_req_d;
        end
    end

    assign busy_o       = busy_q;
    assign exec_start_o = exec_start_q;
    assign exec_req_o   = exec_req_q;
    assign res_strobe_o = res_strobe_q;
    assign res_req_o    = res_req_q;

endmodule

// File: verilog/mac_serial_exec.sv
// Bit-serial signed MAC; operands and acc are sampled on start only, result wraps, no saturation
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_serial_exec (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            start_i,
    input  mac_pkg::exec_req_t              req_i,
    input  logic signed [`MAC_DATA_W-1:0]   acc_i,
    output logic                            done_o,
    output logic signed [`MAC_DATA_W-1:0]   sum_o
);

    // One serial step per multiplier bit
    localparam int STEPS = 2 * `MAC_HALF_W;
    localparam int CNT_W = $clog2(STEPS + 1);
    localparam int DIV_W = $clog2(`MAC_CLK_DIV + 1);

    localparam logic [CNT_W-1:0] STEP_LAST = CNT_W'(STEPS - 1);
    // Counter parks here when no multiply is running
    localparam logic [CNT_W-1:0] STEP_IDLE = CNT_W'(STEPS);
    localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(`MAC_CLK_DIV);

    logic [CNT_W-1:0]               step_cnt;
    logic [DIV_W-1:0]               div_cnt;
    logic                           active;
    logic                           step_en;
    logic                           done_q;
    logic signed [`MAC_DATA_W-1:0]  mcand_q;
    logic signed [`MAC_DATA_W-1:0]  mplier_q;
    logic signed [`MAC_DATA_W-1:0]  sum_q;

    assign active  = (step_cnt != STEP_IDLE);
    // A step happens on each divider wrap
    assign step_en = active && (div_cnt == DIV_LAST);

    // Clock divider, restarted by start
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            div_cnt <= '0;
        end else if (start_i || step_en) begin
            div_cnt <= '0;
        end else if (active) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // Step counter
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            step_cnt <= STEP_IDLE;
        end else if (start_i) begin
            step_cnt <= '0;
        end else if (step_en) begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // Single done pulse after the last step
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= step_en && (step_cnt == STEP_LAST) && !start_i;
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            sum_q    <= acc_i;
            mcand_q  <= req_i.a;
            mplier_q <= req_i.b;
        end else if (step_en) begin
            if (mplier_q[0]) begin
                sum_q <= sum_q + mcand_q;
            end
            // Bits shifted past the top drop out, which gives the modulo wrap
            mcand_q  <= mcand_q <<< 1;
            mplier_q <= mplier_q >>> 1;
        end
    end

    assign done_o = done_q;
    assign sum_o  = sum_q;

endmodule

// File: verilog/mac_result.sv
// Accumulator owner; the two input strobes are assumed never to arrive in the same cycle
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_result (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            res_strobe_i,
    input  mac_pkg::res_req_t               res_req_i,
    input  logic                            exec_done_i,
    input  logic signed [`MAC_DATA_W-1:0]   exec_sum_i,
    output logic signed [`MAC_DATA_W-1:0]   acc_o,
    output logic                            done_o
);

    logic signed [`MAC_DATA_W-1:0]  acc_q;
    logic signed [`MAC_DATA_W-1:0]  acc_d;
    logic                           acc_neg;
    logic                           done_q;

    assign acc_neg = acc_q[`MAC_DATA_W-1];

    // Next accumulator value
    always_comb begin
        acc_d = acc_q;
        if (res_strobe_i) begin
            case (res_req_i.op)
                mac_pkg::RES_CLEAR: begin
                    acc_d = '0;
                end
                mac_pkg::RES_LOAD: begin
                    acc_d = res_req_i.value;
                end
                mac_pkg::RES_RELU: begin
                    // Clamp negatives to zero
                    if (acc_neg) begin
                        acc_d = '0;
                    end
                end
                default: begin
                    acc_d = acc_q;
                end
            endcase
        end else if (exec_done_i) begin
            acc_d = exec_sum_i;
        end
    end

    // Accumulator starts at zero after reset
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= acc_d;
        end
    end

    // Done one cycle after either strobe
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= res_strobe_i || exec_done_i;
        end
    end

    assign acc_o  = acc_q;
    assign done_o = done_q;

endmodule

// File: verilog/mac_unit_top.sv
// MAC unit top; the host must wait for busy_o low, since strobes while busy are ignored
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_unit_top (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            cmd_valid_i,
    input  mac_pkg::mac_cmd_t               cmd_i,
    output logic                            busy_o,
    output logic                            done_o,
    output logic signed [`MAC_DATA_W-1:0]   acc_o
);

    logic                           exec_start;
    mac_pkg::exec_req_t             exec_req;
    logic                           res_strobe;
    mac_pkg::res_req_t              res_req;
    logic                           exec_done;
    logic signed [`MAC_DATA_W-1:0]  exec_sum;

    mac_decode i_decode (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .done_i       (done_o),
        .busy_o       (busy_o),
        .exec_start_o (exec_start),
        .exec_req_o   (exec_req),
        .res_strobe_o (res_strobe),
        .res_req_o    (res_req)
    );

    // Accumulator feeds back into the executer
    mac_serial_exec i_exec (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .start_i (exec_start),
        .req_i   (exec_req),
        .acc_i   (acc_o),
        .done_o  (exec_done),
        .sum_o   (exec_sum)
    );

    mac_result i_result (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .res_strobe_i (res_strobe),
        .res_req_i    (res_req),
        .exec_done_i  (exec_done),
        .exec_sum_i   (exec_sum),
        .acc_o        (acc_o),
        .done_o       (done_o)
    );

endmodule

// File: test/mac_unit_assertions.sv
// Protocol checks on busy_o and done_o; relies on the synchronous active-low reset of the DUT
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_unit_assertions (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            busy_i,
    input  logic                            done_i,
    input  logic signed [`MAC_DATA_W-1:0]   acc_i
);

    // Done is a single-cycle strobe
    a_done_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_i |=> !done_i)
        else $error("done_o stayed high for two cycles");

    // Done only inside a busy window
    a_done_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
        done_i |-> busy_i)
        else $error("done_o pulsed while busy_o was low");

    a_busy_fall: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $fell(busy_i) |-> $past(done_i))
        else $error("busy_o fell without a done_o in the cycle before");

    // Outputs are quiet and the accumulator is zero coming out of a reset edge
    a_reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |=> (!busy_i && !done_i && (acc_i == '0)))
        else $error("outputs active or accumulator nonzero during reset");

endmodule

bind mac_unit_top mac_unit_assertions i_assertions (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .busy_i (busy_o),
    .done_i (done_o),
    .acc_i  (acc_o)
);

// File: test/mac_unit_tb.sv
// Self-checking testbench for mac_unit_top; one command at a time, the unit must be idle before each
`timescale 1ns/1ps
`include "mac_defines.svh"

module mac_unit_tb;

    localparam int NUM_CMDS    = 300;
    // Capture, strobe, serial steps, exec done and result done
    localparam int MAC_LAT     = 2 * `MAC_HALF_W * (`MAC_CLK_DIV + 1) + 4;
    localparam int CYCLE_LIMIT = NUM_CMDS * (2 * MAC_LAT + 10);

    logic                           clk_i;
    logic                           rstn_i;
    logic                           cmd_valid_i;
    mac_pkg::mac_cmd_t              cmd_i;
    logic                           busy_o;
    logic                           done_o;
    logic signed [`MAC_DATA_W-1:0]  acc_o;

    integer                         seed;
    int                             cycle_cnt;
    int                             error_count;
    logic signed [`MAC_DATA_W-1:0]  acc_model;
    mac_pkg::mac_cmd_t              next_cmd;

    mac_unit_top i_dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .acc_o       (acc_o)
    );

    always #20 clk_i = ~clk_i;

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d clock cycles without finishing", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("ERROR at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("TB FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Operands lean towards the extremes now and then
    task automatic random_operand(output logic signed [`MAC_DATA_W-1:0] value);
        int sel;
        sel = $random(seed) & 7;
        case (sel)
            0: value = {1'b1, {(`MAC_DATA_W-1){1'b0}}};
            1: value = {1'b0, {(`MAC_DATA_W-1){1'b1}}};
            2: value = '1;
            3: value = ($random(seed) & 15) - 8;
            default: value = $random(seed);
        endcase
    endtask

    task automatic random_command(output mac_pkg::mac_cmd_t cmd);
        int sel;
        sel = $random(seed) & 7;
        case (sel)
            0: cmd.op = mac_pkg::OP_CLEAR;
            1, 2: cmd.op = mac_pkg::OP_LOAD;
            3, 4, 5: cmd.op = mac_pkg::OP_MAC;
            default: cmd.op = mac_pkg::OP_RELU;
        endcase
        random_operand(cmd.a);
        random_operand(cmd.b);
    endtask

    // Reference behavior of one command
    task automatic update_model(input mac_pkg::mac_cmd_t cmd);
        case (cmd.op)
            mac_pkg::OP_CLEAR: acc_model = '0;
            mac_pkg::OP_LOAD:  acc_model = cmd.a;
            mac_pkg::OP_MAC:   acc_model = acc_model + cmd.a * cmd.b;
            default: begin
                if (acc_model < 0) begin
                    acc_model = '0;
                end
            end
        endcase
    endtask

    task automatic run_command(input mac_pkg::mac_cmd_t cmd);
        int                 cycles;
        mac_pkg::mac_cmd_t  junk;
        while (busy_o !== 1'b0) begin
            @(posedge clk_i);
            #2;
        end
        cmd_valid_i = 1'b1;
        cmd_i       = cmd;
        @(posedge clk_i);
        #2;
        cmd_valid_i = 1'b0;
        check_value("busy_o after capture", busy_o, 1);
        // Values seen here are sampled at the first edge after capture
        cycles = 1;
        while (done_o !== 1'b1) begin
            @(posedge clk_i);
            #2;
            cycles = cycles + 1;
            cmd_valid_i = 1'b0;
            // Strobes while busy must be dropped by the DUT
            if (busy_o && !done_o && (($random(seed) & 3) == 0)) begin
                random_command(junk);
                cmd_valid_i = 1'b1;
                cmd_i       = junk;
            end
        end
        cmd_valid_i = 1'b0;
        update_model(cmd);
        check_value("acc_o at done_o", acc_o, acc_model);
        if (cmd.op != mac_pkg::OP_MAC) begin
            check_value("single-cycle op latency", cycles, 2);
        end
    endtask

    initial begin
        seed        = 76342;
        cycle_cnt   = 0;
        error_count = 0;
        acc_model   = '0;
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_i       = '0;
        repeat (8) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
        check_value("acc_o after reset", acc_o, 0);
        check_value("busy_o after reset", busy_o, 0);
        for (int i = 0; i < NUM_CMDS; i++) begin
            random_command(next_cmd);
            // Start from a known clear accumulator
            if (i == 0) begin
                next_cmd.op = mac_pkg::OP_CLEAR;
            end
            run_command(next_cmd);
        end
        repeat (4) @(posedge clk_i);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+verilog
verilog/mac_pkg.sv
verilog/mac_decode.sv
verilog/mac_serial_exec.sv
verilog/mac_result.sv
verilog/mac_unit_top.sv
test/mac_unit_assertions.sv
test/mac_unit_tb.sv
